// File: common/sigfmd_pkg.sv
package sigfmd_pkg;

    localparam int sig_w  = 53;   // Hidden bit plus 52 fraction bits
    localparam int mop_w  = 58;   // Multiplier operand
    localparam int prod_w = 116;  // Full multiplier product
    localparam int res_w  = 57;   // Significand, guard, round and sticky
    localparam int seed_w = 8;    // Reciprocal seed fraction

    // Significand in [1,2), 1 integer bit and 52 fraction bits
    typedef logic [sig_w-1:0] sig_t;

    // Operand of the multiplier.
    // Significands enter as {sig, 5'b0}, which keeps 1 integer bit
    // and gives 57 fraction bits; A uses the same scale, and the
    // reciprocal x lies below 1 so it keeps 58 fraction bits
    typedef logic [mop_w-1:0] mop_t;

    typedef logic [prod_w-1:0] prod_t;  // Product of two mop_t

    typedef logic [res_w-1:0] res_t;  // Result handed to rounding

    // Seed s stands for the reciprocal 0.5 + s * 2^-9
    typedef logic [seed_w-1:0] seed_t;

    typedef enum logic [3:0] {
        idle,
        mul_issue,   // Single multiply pass
        mul_wait,
        nr_mul_xb,   // x times fb
        nr_wait_xb,
        nr_mul_ax,   // A times x
        nr_wait_ax,
        q_mul,       // Estimate fa times x
        q_wait,
        r_mul,       // Estimate times fb
        r_wait,
        finish
    } ctrl_state_t;

endpackage

// File: logic/recip_rom.sv
module recip_rom #(
    parameter int seed_bits = 8
) (
    input  logic [seed_bits-1:0] addr,
    output sigfmd_pkg::seed_t    data
);

    // Seed nearest to the reciprocal of the interval midpoint.
    // Midpoint is 1 + (2*idx+1) / 2^(seed_bits+1), so the reciprocal
    // scaled by 2^(seed_bits+1) is 2^(2*seed_bits+2) / den
    function automatic sigfmd_pkg::seed_t recip_seed(input int idx);
        int den;
        int quo;
        den = (1 << (seed_bits + 1)) + 2 * idx + 1;
        quo = ((1 << (2 * seed_bits + 3)) + den) / (2 * den);  // Round half up
        return sigfmd_pkg::seed_t'(quo - (1 << seed_bits));    // Drop the 0.5 bit
    endfunction

    sigfmd_pkg::seed_t table_q [2**seed_bits];

    for (genvar i = 0; i < 2**seed_bits; i++) begin : g_entry
        assign table_q[i] = recip_seed(i);  // Constant per entry
    end

    assign data = table_q[addr];

endmodule

// File: logic/mul_tree.sv
module mul_tree (
    input  logic               clk,
    input  logic               rst,
    input  sigfmd_pkg::mop_t   a,
    input  sigfmd_pkg::mop_t   b,
    input  logic               valid_in,
    output sigfmd_pkg::prod_t  prod,
    output logic               valid_out
);

    localparam int half_w = $bits(sigfmd_pkg::mop_t) / 2;

    logic [half_w-1:0] a_hi, a_lo;
    logic [half_w-1:0] b_hi, b_lo;

    logic [2*half_w-1:0] pp_hh, pp_hl, pp_lh, pp_ll;  // Stage one partial products
    logic                valid_pp;

    assign a_hi = a[2*half_w-1:half_w];
    assign a_lo = a[half_w-1:0];
    assign b_hi = b[2*half_w-1:half_w];
    assign b_lo = b[half_w-1:0];

    always_ff @(posedge clk) begin
        pp_hh <= a_hi * b_hi;
        pp_hl <= a_hi * b_lo;
        pp_lh <= a_lo * b_hi;
        pp_ll <= a_lo * b_lo;
    end

    // Cross terms share the middle weight
    always_ff @(posedge clk) begin
        prod <= (sigfmd_pkg::prod_t'(pp_hh) << (2 * half_w))
              + ((sigfmd_pkg::prod_t'(pp_hl) + sigfmd_pkg::prod_t'(pp_lh)) << half_w)
              + sigfmd_pkg::prod_t'(pp_ll);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pp  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_pp  <= valid_in;
            valid_out <= valid_pp;
        end
    end

endmodule

// File: sigfmd/sigfmd_ctrl.sv
module sigfmd_ctrl #(
    parameter int seed_bits = 8,
    parameter int iter_dp   = 3,
    parameter int iter_sp   = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   fdiv,
    input  logic                   db,
    input  sigfmd_pkg::sig_t       fa,
    input  sigfmd_pkg::sig_t       fb,
    output logic                   busy,
    output logic [seed_bits-1:0]   seed_addr,
    input  sigfmd_pkg::seed_t      seed,
    output sigfmd_pkg::mop_t       mul_a,
    output sigfmd_pkg::mop_t       mul_b,
    output logic                   mul_valid,
    input  sigfmd_pkg::prod_t      prod,
    input  logic                   prod_valid,
    output sigfmd_pkg::sig_t       fa_q,
    output sigfmd_pkg::sig_t       fb_q,
    output logic                   op_div,
    output logic                   op_db,
    output sigfmd_pkg::mop_t       est,
    output sigfmd_pkg::prod_t      eb,
    output logic                   sel_go
);

    localparam int iter_max = (iter_dp > iter_sp) ? iter_dp : iter_sp;
    localparam int cnt_w    = $clog2(iter_max + 1);

    sigfmd_pkg::ctrl_state_t state;
    logic [cnt_w-1:0]        iter_cnt;  // Newton iterations left
    sigfmd_pkg::mop_t        x;         // Reciprocal of fb, 58 fraction bits
    sigfmd_pkg::mop_t        a_nr;      // Two minus x times fb
    sigfmd_pkg::mop_t        fa_m;
    sigfmd_pkg::mop_t        fb_m;

    assign fa_m      = {fa_q, 5'b0};
    assign fb_m      = {fb_q, 5'b0};
    assign seed_addr = fb[51 -: seed_bits];  // Read while start is high
    assign busy      = (state != sigfmd_pkg::idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sigfmd_pkg::idle;
            iter_cnt <= '0;
        end else begin
            case (state)
                sigfmd_pkg::idle: begin
                    if (start) begin
                        state    <= fdiv ? sigfmd_pkg::nr_mul_xb : sigfmd_pkg::mul_issue;
                        iter_cnt <= db ? cnt_w'(iter_dp) : cnt_w'(iter_sp);
                    end
                end
                sigfmd_pkg::mul_issue:  state <= sigfmd_pkg::mul_wait;
                sigfmd_pkg::mul_wait: begin
                    if (prod_valid) state <= sigfmd_pkg::idle;  // Result taken by select_fd
                end
                sigfmd_pkg::nr_mul_xb:  state <= sigfmd_pkg::nr_wait_xb;
                sigfmd_pkg::nr_wait_xb: begin
                    if (prod_valid) state <= sigfmd_pkg::nr_mul_ax;
                end
                sigfmd_pkg::nr_mul_ax:  state <= sigfmd_pkg::nr_wait_ax;
                sigfmd_pkg::nr_wait_ax: begin
                    if (prod_valid) begin
                        iter_cnt <= iter_cnt - 1'b1;
                        state    <= (iter_cnt == 1) ? sigfmd_pkg::q_mul : sigfmd_pkg::nr_mul_xb;
                    end
                end
                sigfmd_pkg::q_mul:      state <= sigfmd_pkg::q_wait;
                sigfmd_pkg::q_wait: begin
                    if (prod_valid) state <= sigfmd_pkg::r_mul;
                end
                sigfmd_pkg::r_mul:      state <= sigfmd_pkg::r_wait;
                sigfmd_pkg::r_wait: begin
                    if (prod_valid) state <= sigfmd_pkg::finish;
                end
                sigfmd_pkg::finish:     state <= sigfmd_pkg::idle;
                default:                state <= sigfmd_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sigfmd_pkg::idle && start) begin
            fa_q   <= fa;
            fb_q   <= fb;
            op_div <= fdiv;
            op_db  <= db;
            x      <= {1'b1, seed, {(57 - seed_bits){1'b0}}};  // 0.5 plus seed fraction
        end
        if (state == sigfmd_pkg::nr_wait_xb && prod_valid) begin
            a_nr <= ~prod[115:58];  // Complement gives 2 - x*fb - ulp
        end
        if (state == sigfmd_pkg::nr_wait_ax && prod_valid) begin
            x <= prod[114:57];  // New x stays below 1
        end
        if (state == sigfmd_pkg::q_wait && prod_valid) begin
            est <= op_db ? {prod[115:60], 2'b0}   // 55 quotient fraction bits
                         : {prod[115:89], 31'b0}; // 26 quotient fraction bits
        end
        if (state == sigfmd_pkg::r_wait && prod_valid) begin
            eb <= prod;
        end
    end

    always_comb begin
        mul_a     = fa_m;
        mul_b     = fb_m;
        mul_valid = 1'b0;
        case (state)
            sigfmd_pkg::mul_issue: begin
                mul_valid = 1'b1;
            end
            sigfmd_pkg::nr_mul_xb: begin
                mul_a     = x;
                mul_valid = 1'b1;
            end
            sigfmd_pkg::nr_mul_ax: begin
                mul_a     = a_nr;
                mul_b     = x;
                mul_valid = 1'b1;
            end
            sigfmd_pkg::q_mul: begin
                mul_b     = x;
                mul_valid = 1'b1;
            end
            sigfmd_pkg::r_mul: begin
                mul_a     = est;
                mul_valid = 1'b1;
            end
            default: ;
        endcase
    end

    // Multiply result goes straight from the product register
    assign sel_go = ((state == sigfmd_pkg::mul_wait) && prod_valid)
                  || (state == sigfmd_pkg::finish);

endmodule

// File: sigfmd/select_fd.sv
module select_fd (
    input  logic               clk,
    input  logic               rst,
    input  logic               op_div,
    input  logic               op_db,
    input  sigfmd_pkg::sig_t   fa_q,
    input  sigfmd_pkg::sig_t   fb_q,
    input  sigfmd_pkg::mop_t   est,
    input  sigfmd_pkg::prod_t  eb,
    input  sigfmd_pkg::prod_t  prod,
    input  logic               sel_go,
    output sigfmd_pkg::res_t   fq,
    output logic               done
);

    sigfmd_pkg::prod_t fa_s;    // fa at the 114 fraction bit scale of eb
    sigfmd_pkg::prod_t rem;     // fa minus est times fb
    sigfmd_pkg::prod_t fb_ulp;  // fb times one quotient unit
    sigfmd_pkg::prod_t rem_fin;
    logic              inc;
    logic              sticky_div;
    logic [55:0]       q_dp;
    logic [26:0]       q_sp;
    sigfmd_pkg::res_t  fq_mul;
    sigfmd_pkg::res_t  fq_div;

    // Product of {fa,5'b0} and {fb,5'b0} sits ten bits up
    assign fq_mul = {prod[115:60], |prod[59:0]};

    assign fa_s   = sigfmd_pkg::prod_t'(fa_q) << 62;
    assign rem    = fa_s - eb;  // Estimate never exceeds the quotient
    assign fb_ulp = op_db ? (sigfmd_pkg::prod_t'(fb_q) << 7)
                          : (sigfmd_pkg::prod_t'(fb_q) << 36);

    assign inc        = (rem >= fb_ulp);  // Estimate is one unit short
    assign rem_fin    = inc ? (rem - fb_ulp) : rem;
    assign sticky_div = |rem_fin;

    assign q_dp = est[57:2] + inc;
    assign q_sp = est[57:31] + inc;

    assign fq_div = op_db ? {q_dp, sticky_div}
                          : {q_sp, sticky_div, 29'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            fq   <= '0;
            done <= 1'b0;
        end else begin
            done <= sel_go;
            if (sel_go) begin
                fq <= op_div ? fq_div : fq_mul;  // Held until the next operation
            end
        end
    end

endmodule

// File: sigfmd/sigfmd.sv
module sigfmd #(
    parameter int seed_bits = 8,
    parameter int iter_dp   = 3,
    parameter int iter_sp   = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               fdiv,
    input  logic               db,
    input  sigfmd_pkg::sig_t   fa,
    input  sigfmd_pkg::sig_t   fb,
    output sigfmd_pkg::res_t   fq,
    output logic               done,
    output logic               busy
);

    logic [seed_bits-1:0] seed_addr;
    sigfmd_pkg::seed_t    seed;
    sigfmd_pkg::mop_t     mul_a;
    sigfmd_pkg::mop_t     mul_b;
    logic                 mul_valid;
    sigfmd_pkg::prod_t    prod;
    logic                 prod_valid;
    sigfmd_pkg::sig_t     fa_q;
    sigfmd_pkg::sig_t     fb_q;
    logic                 op_div;
    logic                 op_db;
    sigfmd_pkg::mop_t     est;
    sigfmd_pkg::prod_t    eb;
    logic                 sel_go;

    recip_rom #(.seed_bits(seed_bits)) u_rom (.addr(seed_addr), .data(seed));

    sigfmd_ctrl #(
        .seed_bits(seed_bits),
        .iter_dp  (iter_dp),
        .iter_sp  (iter_sp)
    ) u_ctrl (
        .clk(clk), .rst(rst), .start(start), .fdiv(fdiv), .db(db),
        .fa(fa), .fb(fb), .busy(busy), .seed_addr(seed_addr), .seed(seed),
        .mul_a(mul_a), .mul_b(mul_b), .mul_valid(mul_valid),
        .prod(prod), .prod_valid(prod_valid), .fa_q(fa_q), .fb_q(fb_q),
        .op_div(op_div), .op_db(op_db), .est(est), .eb(eb), .sel_go(sel_go)
    );

    mul_tree u_mul (
        .clk(clk), .rst(rst), .a(mul_a), .b(mul_b), .valid_in(mul_valid),
        .prod(prod), .valid_out(prod_valid)
    );

    select_fd u_sel (
        .clk(clk), .rst(rst), .op_div(op_div), .op_db(op_db),
        .fa_q(fa_q), .fb_q(fb_q), .est(est), .eb(eb), .prod(prod),
        .sel_go(sel_go), .fq(fq), .done(done)
    );

endmodule

// File: tb/sigfmd_chk.sv
module sigfmd_chk (
    input logic             clk,
    input logic             rst,
    input logic             start,
    input logic             fdiv,
    input logic             busy,
    input logic             done,
    input logic             mul_valid,
    input logic             sel_go,
    input logic             op_div,
    input logic             op_db,
    input sigfmd_pkg::res_t fq,
    input sigfmd_pkg::sig_t fa_q,
    input sigfmd_pkg::sig_t fb_q
);

    int fail_cnt = 0;  // Failed assertions so far

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_cnt++;
        end

    // Issue, two multiplier stages, then the select register
    assert property (@(posedge clk) disable iff (rst)
            start && !busy && !fdiv |=> !done [*3] ##1 done)
        else begin
            $error("done did not follow a multiply start after exactly 4 cycles");
            fail_cnt++;
        end

    assert property (@(posedge clk)
            rst |=> !busy && !done && !mul_valid && !sel_go && fq == '0)
        else begin
            $error("control outputs or fq not cleared by reset");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (rst)
            start && busy |=> $stable(fa_q) && $stable(fb_q) && $stable(op_div)
                              && $stable(op_db))
        else begin
            $error("a start while busy changed the latched operands");
            fail_cnt++;
        end

endmodule

bind sigfmd sigfmd_chk u_chk (
    .clk(clk), .rst(rst), .start(start), .fdiv(fdiv), .busy(busy), .done(done),
    .mul_valid(mul_valid), .sel_go(sel_go), .op_div(op_div), .op_db(op_db),
    .fq(fq), .fa_q(fa_q), .fb_q(fb_q)
);

// File: tb/sigfmd_tb.sv
module sigfmd_tb;

    localparam int seed_bits  = 8;
    localparam int iter_dp    = 3;
    localparam int iter_sp    = 2;
    localparam int clk_period = 40;
    localparam int drive_dly  = 2;   // Input change after the rising edge
    localparam int rst_cycles = 16;
    localparam int n_mul_dp   = 300;
    localparam int n_div_dp   = 300;
    localparam int n_sp       = 200;  // Each of multiply and divide
    localparam int n_edge     = 12;
    localparam int n_b2b      = 40;
    localparam int n_ops      = n_mul_dp + n_div_dp + 2 * n_sp + n_edge + 1 + n_b2b;
    // Double divide makes 2 passes per iteration plus 2 more at 3 cycles each
    localparam int op_cycles  = (2 * iter_dp + 2) * 3 + 6;
    localparam int op_limit   = 2 * op_cycles;
    localparam int wd_time    = (rst_cycles + n_ops * op_cycles + 64) * clk_period;

    logic             clk = 1'b0;
    logic             rst;
    logic             start;
    logic             fdiv;
    logic             db;
    sigfmd_pkg::sig_t fa;
    sigfmd_pkg::sig_t fb;
    sigfmd_pkg::res_t fq;
    logic             done;
    logic             busy;

    logic [31:0] lfsr = 32'd88824;

    sigfmd #(
        .seed_bits(seed_bits),
        .iter_dp  (iter_dp),
        .iter_sp  (iter_sp)
    ) UUT (
        .clk(clk), .rst(rst), .start(start), .fdiv(fdiv), .db(db),
        .fa(fa), .fb(fb), .fq(fq), .done(done), .busy(busy)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // Single precision keeps 23 fraction bits and zeros the rest
    task automatic rand_sig(input logic dbl, output sigfmd_pkg::sig_t s);
        logic [63:0] r;
        if (dbl) begin
            take_bits(52, r);
            s = {1'b1, r[51:0]};
        end else begin
            take_bits(23, r);
            s = {1'b1, r[22:0], 29'b0};
        end
    endtask

    // Exact quotient and product from wide integers
    function automatic sigfmd_pkg::res_t model_fq(input logic op_div, input logic dbl,
            input sigfmd_pkg::sig_t a, input sigfmd_pkg::sig_t b);
        logic [127:0] p;
        logic [127:0] num;
        logic [127:0] q;
        logic [127:0] r;
        if (!op_div) begin
            p = 128'(a) * 128'(b);
            return {p[105:50], |p[49:0]};
        end
        num = dbl ? (128'(a) << 55) : (128'(a) << 26);
        q   = num / 128'(b);
        r   = num % 128'(b);
        if (dbl) begin
            return {q[55:0], |r};
        end
        return {q[26:0], |r, 29'b0};
    endfunction

    task automatic expect_eq(input string name, input logic [63:0] want,
            input logic [63:0] got);
        assert (got === want) else begin
            $display("ERR %s: expected %h, actual %h", name, want, got);
            abort_run();
        end
    endtask

    // Counts the cycles from start up to the rising edge where done is seen
    task automatic wait_done(input string name, output int n);
        n = 0;
        do begin
            @(posedge clk);
            #drive_dly;
            start = 1'b0;
            n++;
        end while (!done && n < op_limit);
        if (!done) begin
            $display("Test %s got no done from the DUT within %0d cycles", name, op_limit);
            abort_run();
        end
    endtask

    task automatic run_op(input string name, input logic op_div, input logic dbl,
            input sigfmd_pkg::sig_t a, input sigfmd_pkg::sig_t b);
        sigfmd_pkg::res_t want;
        int n;
        want  = model_fq(op_div, dbl, a, b);
        start = 1'b1;
        fdiv  = op_div;
        db    = dbl;
        fa    = a;
        fb    = b;
        wait_done(name, n);
        expect_eq(name, 64'(want), 64'(fq));
        if (!op_div) begin
            expect_eq({name, " latency"}, 64'd4, 64'(n));
        end
    endtask

    task automatic edge_divides();
        sigfmd_pkg::sig_t one;
        sigfmd_pkg::sig_t top;
        sigfmd_pkg::sig_t r;
        logic dbl;
        for (int k = 0; k < 2; k++) begin
            dbl = (k == 0);
            one = {1'b1, 52'b0};
            top = dbl ? {53{1'b1}} : {1'b1, 23'h7fffff, 29'b0};  // Last seed entry
            rand_sig(dbl, r);
            run_op("edge fa=fb", 1'b1, dbl, r, r);
            run_op("edge fb=1", 1'b1, dbl, r, one);
            run_op("edge fa max fb=1", 1'b1, dbl, top, one);
            run_op("edge fb max", 1'b1, dbl, r, top);
            run_op("edge fa=fb max", 1'b1, dbl, top, top);
            run_op("edge fa=1 fb max", 1'b1, dbl, one, top);
        end
    endtask

    task automatic restart_while_busy(input string name);
        sigfmd_pkg::sig_t a1, b1, a2, b2;
        sigfmd_pkg::res_t want;
        int n;
        rand_sig(1'b1, a1);
        rand_sig(1'b1, b1);
        rand_sig(1'b1, a2);
        rand_sig(1'b1, b2);
        want  = model_fq(1'b1, 1'b1, a1, b1);
        start = 1'b1;
        fdiv  = 1'b1;
        db    = 1'b1;
        fa    = a1;
        fb    = b1;
        repeat (4) begin
            @(posedge clk);
            #drive_dly;
            start = 1'b0;
        end
        assert (busy) else begin
            $display("DUT was not busy when the second start was pulsed in %s", name);
            abort_run();
        end
        fa    = a2;  // Second operation is a single multiply
        fb    = b2;
        fdiv  = 1'b0;
        db    = 1'b0;
        start = 1'b1;
        wait_done(name, n);
        expect_eq(name, 64'(want), 64'(fq));
        repeat (6) begin
            @(posedge clk);
            #drive_dly;
            assert (!done && !busy) else begin
                $display("A start pulsed while busy launched an operation in %s", name);
                abort_run();
            end
        end
    endtask

    always @(posedge clk) begin
        if (UUT.u_chk.fail_cnt != 0) begin
            $display("A concurrent assertion in the bound checker failed");
            abort_run();
        end
    end

    initial begin
        sigfmd_pkg::sig_t a;
        sigfmd_pkg::sig_t b;
        rst   = 1'b1;
        start = 1'b0;
        fdiv  = 1'b0;
        db    = 1'b0;
        fa    = '0;
        fb    = '0;
        repeat (rst_cycles) @(posedge clk);
        #drive_dly;
        rst = 1'b0;
        for (int i = 0; i < n_mul_dp; i++) begin
            rand_sig(1'b1, a);
            rand_sig(1'b1, b);
            run_op("mul dp", 1'b0, 1'b1, a, b);
        end
        for (int i = 0; i < n_div_dp; i++) begin
            rand_sig(1'b1, a);
            rand_sig(1'b1, b);
            run_op("div dp", 1'b1, 1'b1, a, b);
        end
        for (int i = 0; i < n_sp; i++) begin
            rand_sig(1'b0, a);
            rand_sig(1'b0, b);
            run_op("mul sp", 1'b0, 1'b0, a, b);
            rand_sig(1'b0, a);
            rand_sig(1'b0, b);
            run_op("div sp", 1'b1, 1'b0, a, b);
        end
        edge_divides();
        restart_while_busy("start while busy");
        for (int i = 0; i < n_b2b; i++) begin
            rand_sig(i[1], a);
            rand_sig(i[1], b);
            run_op("back to back", i[0], i[1], a, b);  // Cycles through all four modes
        end
        if (UUT.u_chk.fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d concurrent assertion failures were seen", UUT.u_chk.fail_cnt);
            abort_run();
        end
    end

    initial begin
        #(wd_time);
        $display("Watchdog timeout, the run did not finish within %0d time units", wd_time);
        abort_run();
    end

endmodule

// File: verilog.f
common/sigfmd_pkg.sv
logic/recip_rom.sv
logic/mul_tree.sv
sigfmd/sigfmd_ctrl.sv
sigfmd/select_fd.sv
sigfmd/sigfmd.sv
tb/sigfmd_chk.sv
tb/sigfmd_tb.sv

// File: Bender.yml
package:
  name: sigfmd

sources:
  - files:
      - common/sigfmd_pkg.sv
  - files:
      - logic/recip_rom.sv
      - logic/mul_tree.sv
      - sigfmd/sigfmd_ctrl.sv
      - sigfmd/select_fd.sv
      - sigfmd/sigfmd.sv
  - target: test
    files:
      - tb/sigfmd_chk.sv
      - tb/sigfmd_tb.sv
